// ==== hdl/dtlb_settings.svh ====
`ifndef DTLB_SETTINGS_SVH
`define DTLB_SETTINGS_SVH

// Page number width
// Virtual and physical page numbers are the same size
`define DTLB_VPN_W 20

// Tag is taken from the upper bits of the page number
`define DTLB_TAG_W 16

// Set index is taken from the lower bits of the page number
`define DTLB_SET_W 4

// Number of sets
`define DTLB_SETS 16

// Ways per set
// The one-bit replacement scheme only works with two
`define DTLB_WAYS 2

// Raw flag bits from one page table level
`define DTLB_FLAG_W 4

`endif

// ==== hdl/dtlb_pkg.sv ====
`default_nettype none

`include "dtlb_settings.svh"

package dtlb_pkg;

   // Page flags, present in the lowest bit
   typedef struct packed {
      logic global;
      logic kernel;
      logic writeable;
      logic present;
   } page_flags_t;

   // One TLB way entry
   typedef struct packed {
      logic                   valid;
      logic [`DTLB_TAG_W-1:0] tag;
      logic [`DTLB_VPN_W-1:0] ppn;
      page_flags_t            flags;
   } tlb_entry_t;

   // Lookup request from one port
   typedef struct packed {
      logic                   re;
      logic [`DTLB_VPN_W-1:0] vpn;
   } lookup_req_t;

   // Translation result for one port
   typedef struct packed {
      logic [`DTLB_VPN_W-1:0] ppn;
      page_flags_t            flags;
   } lookup_rsp_t;

   // Walk request
   // re is a single-cycle strobe, vpn is held for the whole walk
   typedef struct packed {
      logic                   re;
      logic [`DTLB_VPN_W-1:0] vpn;
   } ptw_req_t;

   // Walk answer with raw flags from both levels
   typedef struct packed {
      logic                    ready;
      logic [`DTLB_VPN_W-1:0]  ppn;
      logic [`DTLB_FLAG_W-1:0] pt_flags;
      logic [`DTLB_FLAG_W-1:0] pd_flags;
   } ptw_rsp_t;

   // Lookup controller states
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_COMPARE,
      ST_WALK_A,
      ST_WALK_B,
      ST_DELAY
   } ctrl_state_e;

endpackage

`default_nettype wire

// ==== hdl/dtlb_entry_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dtlb_settings.svh"

module dtlb_entry_ram import dtlb_pkg::*; (
   input  logic                   clk,
   input  logic                   reset,
   input  logic [`DTLB_SET_W-1:0] rd_set_a,
   input  logic [`DTLB_SET_W-1:0] rd_set_b,
   input  logic [`DTLB_TAG_W-1:0] tag_a,
   input  logic [`DTLB_TAG_W-1:0] tag_b,
   input  tlb_entry_t             fill_a,
   input  tlb_entry_t             fill_b,
   input  logic                   fill_en_a,
   input  logic                   fill_en_b,
   input  logic                   evict_a,
   input  logic                   evict_b,
   output logic                   hit_a,
   output logic                   hit_b,
   output logic                   hit_way_a,
   output logic                   hit_way_b,
   output lookup_rsp_t            rsp_a,
   output lookup_rsp_t            rsp_b
);

   // Valid bits and tags live in flops so the compare is combinational
   logic [`DTLB_WAYS-1:0]  valid_q [`DTLB_SETS];
   logic [`DTLB_TAG_W-1:0] tag_q [`DTLB_SETS][`DTLB_WAYS];
   // Translation payload
   lookup_rsp_t            data_mem [`DTLB_SETS][`DTLB_WAYS];

   // Per-way match on the read cycle, one-hot
   logic [`DTLB_WAYS-1:0]  way_a_d;
   logic [`DTLB_WAYS-1:0]  way_b_d;
   logic [`DTLB_WAYS-1:0]  way_a_q;
   logic [`DTLB_WAYS-1:0]  way_b_q;
   // Read set, registered like a synchronous RAM address
   logic [`DTLB_SET_W-1:0] set_a_q;
   logic [`DTLB_SET_W-1:0] set_b_q;

   // Tag compare against the set being read
   always_comb begin
      for (int w = 0; w < `DTLB_WAYS; w++) begin
         way_a_d[w] = valid_q[rd_set_a][w] && (tag_q[rd_set_a][w] == tag_a);
         way_b_d[w] = valid_q[rd_set_b][w] && (tag_q[rd_set_b][w] == tag_b);
      end
   end

   // Valid bits start cleared
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int s = 0; s < `DTLB_SETS; s++) begin
            valid_q[s] <= '0;
         end
      end else begin
         if (fill_en_a) valid_q[rd_set_a][evict_a] <= fill_a.valid;
         if (fill_en_b) valid_q[rd_set_b][evict_b] <= fill_b.valid;
      end
   end

   // Refill goes into the way named by the replacement bit
   always_ff @(posedge clk) begin
      if (fill_en_a) begin
         tag_q[rd_set_a][evict_a]    <= fill_a.tag;
         data_mem[rd_set_a][evict_a] <= '{ppn: fill_a.ppn, flags: fill_a.flags};
      end
      if (fill_en_b) begin
         tag_q[rd_set_b][evict_b]    <= fill_b.tag;
         data_mem[rd_set_b][evict_b] <= '{ppn: fill_b.ppn, flags: fill_b.flags};
      end
   end

   // Hit way register
   // After a refill it points at the freshly written way
   always_ff @(posedge clk) begin
      set_a_q <= rd_set_a;
      set_b_q <= rd_set_b;
      if (reset) begin
         way_a_q <= '0;
         way_b_q <= '0;
      end else begin
         way_a_q <= fill_en_a ? {evict_a, ~evict_a} : way_a_d;
         way_b_q <= fill_en_b ? {evict_b, ~evict_b} : way_b_d;
      end
   end

   assign hit_a     = |way_a_q;
   assign hit_b     = |way_b_q;
   assign hit_way_a = way_a_q[1];
   assign hit_way_b = way_b_q[1];

   // Response always comes out of the array
   assign rsp_a = data_mem[set_a_q][way_a_q[1]];
   assign rsp_b = data_mem[set_b_q][way_b_q[1]];

endmodule

`default_nettype wire

// ==== hdl/dtlb_replace.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dtlb_settings.svh"

module dtlb_replace (
   input  logic                   clk,
   input  logic                   reset,
   input  logic [`DTLB_SET_W-1:0] set_a,
   input  logic [`DTLB_SET_W-1:0] set_b,
   input  logic                   upd_hit_a,
   input  logic                   upd_hit_b,
   input  logic                   upd_fill_a,
   input  logic                   upd_fill_b,
   input  logic                   hit_way_a,
   input  logic                   hit_way_b,
   output logic                   evict_a,
   output logic                   evict_b
);

   // One bit per set naming the next way to replace
   logic [`DTLB_SETS-1:0]  evict_q;
   // Set of the previous read
   // Lines up with the registered hit way from the storage
   logic [`DTLB_SET_W-1:0] set_a_q;
   logic [`DTLB_SET_W-1:0] set_b_q;

   always_ff @(posedge clk) begin
      set_a_q <= set_a;
      set_b_q <= set_b;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         evict_q <= '0;
      end else begin
         // Hit keeps the used way and points at the other one
         if (upd_hit_a) evict_q[set_a_q] <= ~hit_way_a;
         else if (upd_fill_a) evict_q[set_a_q] <= ~evict_q[set_a_q];
         // Port B last so it wins on a shared set
         if (upd_hit_b) evict_q[set_b_q] <= ~hit_way_b;
         else if (upd_fill_b) evict_q[set_b_q] <= ~evict_q[set_b_q];
      end
   end

   // Victim way for the set being read
   assign evict_a = evict_q[set_a];
   assign evict_b = evict_q[set_b];

endmodule

`default_nettype wire

// ==== hdl/dtlb_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dtlb_settings.svh"

module dtlb_ctrl import dtlb_pkg::*; (
   input  logic                   clk,
   input  logic                   reset,
   input  lookup_req_t            req_a,
   input  lookup_req_t            req_b,
   input  logic                   hit_a,
   input  logic                   hit_b,
   input  ptw_rsp_t               ptw_rsp,
   output logic                   ready,
   output ptw_req_t               ptw_req,
   output logic [`DTLB_SET_W-1:0] rd_set_a,
   output logic [`DTLB_SET_W-1:0] rd_set_b,
   output tlb_entry_t             fill_a,
   output tlb_entry_t             fill_b,
   output logic                   fill_en_a,
   output logic                   fill_en_b,
   output logic                   upd_hit_a,
   output logic                   upd_hit_b,
   output logic                   upd_fill_a,
   output logic                   upd_fill_b
);

   ctrl_state_e            state_q;
   ctrl_state_e            state_d;

   // Requests held for compare and walks
   lookup_req_t            req_a_q;
   lookup_req_t            req_b_q;
   // B missed in compare and still needs its answer
   logic                   need_b_q;

   // Walker answer, registered
   logic                   ptw_ready_q;
   logic [`DTLB_VPN_W-1:0] walk_ppn_q;
   page_flags_t            walk_flags_q;

   page_flags_t            pd_flags;
   page_flags_t            pt_flags;
   page_flags_t            merged_flags;

   logic                   accept;
   logic                   start_walk;
   logic                   walk_b_sel;
   logic                   same_page;

   // Idle, or compare with every requested port hitting
   assign ready = (state_q == ST_IDLE) ||
                  ((state_q == ST_COMPARE) &&
                   (!req_a_q.re || hit_a) &&
                   (!req_b_q.re || hit_b));

   assign accept    = ready && (req_a.re || req_b.re);
   assign same_page = (req_a_q.vpn == req_b_q.vpn);

   // New set on acceptance, held set otherwise
   assign rd_set_a = accept ? req_a.vpn[`DTLB_SET_W-1:0] : req_a_q.vpn[`DTLB_SET_W-1:0];
   assign rd_set_b = accept ? req_b.vpn[`DTLB_SET_W-1:0] : req_b_q.vpn[`DTLB_SET_W-1:0];

   always_comb begin
      state_d    = state_q;
      start_walk = 1'b0;
      fill_en_a  = 1'b0;
      fill_en_b  = 1'b0;
      upd_hit_a  = 1'b0;
      upd_hit_b  = 1'b0;
      upd_fill_a = 1'b0;
      upd_fill_b = 1'b0;
      case (state_q)
         ST_IDLE: begin
            if (accept) state_d = ST_COMPARE;
         end
         ST_COMPARE: begin
            // Hits refresh the replacement bit
            upd_hit_a = req_a_q.re && hit_a;
            upd_hit_b = req_b_q.re && hit_b;
            // Port A walks first
            if (req_a_q.re && !hit_a) begin
               state_d    = ST_WALK_A;
               start_walk = 1'b1;
            end else if (req_b_q.re && !hit_b) begin
               state_d    = ST_WALK_B;
               start_walk = 1'b1;
            end else if (accept) begin
               // Back-to-back hit lookup
               state_d = ST_COMPARE;
            end else begin
               state_d = ST_IDLE;
            end
         end
         ST_WALK_A: begin
            if (ptw_ready_q) begin
               fill_en_a  = 1'b1;
               upd_fill_a = 1'b1;
               if (need_b_q && same_page) begin
                  // Same page on B
                  // Wait one cycle and read the new entry back
                  state_d = ST_DELAY;
               end else if (need_b_q) begin
                  state_d    = ST_WALK_B;
                  start_walk = 1'b1;
               end else begin
                  // No compare right after a refill
                  state_d = ST_IDLE;
               end
            end
         end
         ST_WALK_B: begin
            if (ptw_ready_q) begin
               fill_en_b  = 1'b1;
               upd_fill_b = 1'b1;
               state_d    = ST_IDLE;
            end
         end
         ST_DELAY: begin
            state_d = ST_IDLE;
         end
         default: begin
            state_d = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state_q     <= ST_IDLE;
         ptw_ready_q <= 1'b0;
         need_b_q    <= 1'b0;
      end else begin
         state_q     <= state_d;
         ptw_ready_q <= ptw_rsp.ready;
         if (state_q == ST_COMPARE) need_b_q <= req_b_q.re && !hit_b;
      end
   end

   // Request latch
   always_ff @(posedge clk) begin
      if (reset) begin
         req_a_q.re <= 1'b0;
         req_b_q.re <= 1'b0;
      end else if (accept) begin
         req_a_q <= req_a;
         req_b_q <= req_b;
      end
   end

   // Raw walker flags seen as page flags
   assign pd_flags = page_flags_t'(ptw_rsp.pd_flags);
   assign pt_flags = page_flags_t'(ptw_rsp.pt_flags);

   // Present and writeable need both levels
   // Kernel and global come from either level
   always_comb begin
      merged_flags.present   = pd_flags.present & pt_flags.present;
      merged_flags.writeable = pd_flags.writeable & pt_flags.writeable;
      merged_flags.kernel    = pd_flags.kernel | pt_flags.kernel;
      merged_flags.global    = pd_flags.global | pt_flags.global;
   end

   // Walk result held until the refill edge
   always_ff @(posedge clk) begin
      if (ptw_rsp.ready) begin
         walk_ppn_q   <= ptw_rsp.ppn;
         walk_flags_q <= merged_flags;
      end
   end

   // Refill entries share the walk result
   always_comb begin
      fill_a.valid = 1'b1;
      fill_a.tag   = req_a_q.vpn[`DTLB_VPN_W-1 -: `DTLB_TAG_W];
      fill_a.ppn   = walk_ppn_q;
      fill_a.flags = walk_flags_q;
      fill_b.valid = 1'b1;
      fill_b.tag   = req_b_q.vpn[`DTLB_VPN_W-1 -: `DTLB_TAG_W];
      fill_b.ppn   = walk_ppn_q;
      fill_b.flags = walk_flags_q;
   end

   // Walk page follows the port being walked
   assign walk_b_sel = (state_q == ST_WALK_B) || (state_d == ST_WALK_B);
   assign ptw_req.re  = start_walk;
   assign ptw_req.vpn = walk_b_sel ? req_b_q.vpn : req_a_q.vpn;

endmodule

`default_nettype wire

// ==== hdl/dtlb_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dtlb_settings.svh"

module dtlb_top import dtlb_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  lookup_req_t req_a,
   input  lookup_req_t req_b,
   output lookup_rsp_t rsp_a,
   output lookup_rsp_t rsp_b,
   output logic        ready,
   output ptw_req_t    ptw_req,
   input  ptw_rsp_t    ptw_rsp
);

   // Controller to storage
   logic [`DTLB_SET_W-1:0] rd_set_a;
   logic [`DTLB_SET_W-1:0] rd_set_b;
   tlb_entry_t             fill_a;
   tlb_entry_t             fill_b;
   logic                   fill_en_a;
   logic                   fill_en_b;

   // Storage back to controller and replacement
   logic                   hit_a;
   logic                   hit_b;
   logic                   hit_way_a;
   logic                   hit_way_b;

   // Replacement state
   logic                   upd_hit_a;
   logic                   upd_hit_b;
   logic                   upd_fill_a;
   logic                   upd_fill_b;
   logic                   evict_a;
   logic                   evict_b;

   dtlb_ctrl ctrl (
      .clk        (clk),
      .reset      (reset),
      .req_a      (req_a),
      .req_b      (req_b),
      .hit_a      (hit_a),
      .hit_b      (hit_b),
      .ptw_rsp    (ptw_rsp),
      .ready      (ready),
      .ptw_req    (ptw_req),
      .rd_set_a   (rd_set_a),
      .rd_set_b   (rd_set_b),
      .fill_a     (fill_a),
      .fill_b     (fill_b),
      .fill_en_a  (fill_en_a),
      .fill_en_b  (fill_en_b),
      .upd_hit_a  (upd_hit_a),
      .upd_hit_b  (upd_hit_b),
      .upd_fill_a (upd_fill_a),
      .upd_fill_b (upd_fill_b)
   );

   // Tags go straight from the request ports
   dtlb_entry_ram entries (
      .clk       (clk),
      .reset     (reset),
      .rd_set_a  (rd_set_a),
      .rd_set_b  (rd_set_b),
      .tag_a     (req_a.vpn[`DTLB_VPN_W-1 -: `DTLB_TAG_W]),
      .tag_b     (req_b.vpn[`DTLB_VPN_W-1 -: `DTLB_TAG_W]),
      .fill_a    (fill_a),
      .fill_b    (fill_b),
      .fill_en_a (fill_en_a),
      .fill_en_b (fill_en_b),
      .evict_a   (evict_a),
      .evict_b   (evict_b),
      .hit_a     (hit_a),
      .hit_b     (hit_b),
      .hit_way_a (hit_way_a),
      .hit_way_b (hit_way_b),
      .rsp_a     (rsp_a),
      .rsp_b     (rsp_b)
   );

   dtlb_replace replace (
      .clk        (clk),
      .reset      (reset),
      .set_a      (rd_set_a),
      .set_b      (rd_set_b),
      .upd_hit_a  (upd_hit_a),
      .upd_hit_b  (upd_hit_b),
      .upd_fill_a (upd_fill_a),
      .upd_fill_b (upd_fill_b),
      .hit_way_a  (hit_way_a),
      .hit_way_b  (hit_way_b),
      .evict_a    (evict_a),
      .evict_b    (evict_b)
   );

endmodule

`default_nettype wire

// ==== tests/ptw_model.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dtlb_settings.svh"

module ptw_model import dtlb_pkg::*; (
   input  logic     clk,
   input  ptw_req_t ptw_req,
   output ptw_rsp_t ptw_rsp,
   output int       walk_count
);

   // Raw flags per level indexed by the low two page number bits
   // Bit order is global, kernel, writeable, present
   localparam logic [`DTLB_FLAG_W-1:0] pd_table [4] = '{4'b0011, 4'b0101, 4'b0010, 4'b1111};
   localparam logic [`DTLB_FLAG_W-1:0] pt_table [4] = '{4'b0011, 4'b1011, 4'b0111, 4'b0000};

   // Page under walk and remaining cycles
   logic [`DTLB_VPN_W-1:0] vpn_q   = '0;
   int                     delay_q = 0;
   logic                   busy_q  = 1'b0;
   // Answer and strobe counter
   ptw_rsp_t               rsp_q   = '0;
   int                     count_q = 0;

   assign ptw_rsp    = rsp_q;
   assign walk_count = count_q;

   // Works on the falling edge like the rest of the stimulus
   initial begin
      // Latency sequence repeats from run to run
      void'($urandom(32'ha710));
      forever begin
         @(negedge clk);
         // Ready is a one-cycle pulse
         rsp_q.ready <= 1'b0;
         if (ptw_req.re) begin
            count_q <= count_q + 1;
            vpn_q   <= ptw_req.vpn;
            // Latency of one to four cycles
            delay_q <= 1 + int'($urandom % 4);
            busy_q  <= 1'b1;
         end else if (busy_q) begin
            if (delay_q == 1) begin
               rsp_q.ready    <= 1'b1;
               rsp_q.ppn      <= vpn_q ^ 20'h5a5a5;
               rsp_q.pd_flags <= pd_table[vpn_q[1:0]];
               rsp_q.pt_flags <= pt_table[vpn_q[1:0]];
               busy_q         <= 1'b0;
            end
            delay_q <= delay_q - 1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== tests/dtlb_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dtlb_settings.svh"

module dtlb_tb import dtlb_pkg::*; ();

   localparam int row_count      = 14;
   localparam int timeout_cycles = 64;

   // Request per port, expected answer per port, expected number of walks
   typedef struct packed {
      logic                    re_a;
      logic [`DTLB_VPN_W-1:0]  vpn_a;
      logic                    re_b;
      logic [`DTLB_VPN_W-1:0]  vpn_b;
      logic [`DTLB_VPN_W-1:0]  ppn_a;
      logic [`DTLB_FLAG_W-1:0] flags_a;
      logic [`DTLB_VPN_W-1:0]  ppn_b;
      logic [`DTLB_FLAG_W-1:0] flags_b;
      logic [3:0]              walks;
   } row_t;

   logic        clk = 1'b0;
   logic        reset;
   lookup_req_t req_a;
   lookup_req_t req_b;
   lookup_rsp_t rsp_a;
   lookup_rsp_t rsp_b;
   logic        ready;
   ptw_req_t    ptw_req;
   ptw_rsp_t    ptw_rsp;
   int          walk_count;

   row_t        rows [row_count];
   int          errors;
   int          row_errors;
   int          walks_before;
   int          cycles;
   logic        timed_out;

   // 8 ns period
   always #4 clk = ~clk;

   dtlb_top UUT (
      .clk     (clk),
      .reset   (reset),
      .req_a   (req_a),
      .req_b   (req_b),
      .rsp_a   (rsp_a),
      .rsp_b   (rsp_b),
      .ready   (ready),
      .ptw_req (ptw_req),
      .ptw_rsp (ptw_rsp)
   );

   ptw_model walker (
      .clk        (clk),
      .ptw_req    (ptw_req),
      .ptw_rsp    (ptw_rsp),
      .walk_count (walk_count)
   );

   // Expected ppn is vpn ^ 5a5a5 and flags are merged from the walker table
   // Set index is the low nibble, flag table index the low two bits
   task automatic load_table();
      // Cold miss on A, then the same page again as a hit
      rows[0]  = '{1'b1, 20'h12340, 1'b0, 20'h00000, 20'h486e5, 4'b0011, 20'h0, 4'h0, 4'd1};
      rows[1]  = '{1'b1, 20'h12340, 1'b0, 20'h00000, 20'h486e5, 4'b0011, 20'h0, 4'h0, 4'd0};
      // Two misses on different pages, then swapped ports hit the shared entries
      rows[2]  = '{1'b1, 20'h0abc1, 1'b1, 20'h7f012, 20'h50e64, 4'b1101, 20'h255b7, 4'b0110, 4'd2};
      rows[3]  = '{1'b1, 20'h7f012, 1'b1, 20'h0abc1, 20'h255b7, 4'b0110, 20'h50e64, 4'b1101, 4'd0};
      // Same page on both ports makes one walk
      rows[4]  = '{1'b1, 20'h31a53, 1'b1, 20'h31a53, 20'h6bff6, 4'b1100, 20'h6bff6, 4'b1100, 4'd1};
      rows[5]  = '{1'b1, 20'h31a53, 1'b1, 20'h31a53, 20'h6bff6, 4'b1100, 20'h6bff6, 4'b1100, 4'd0};
      // X fills way 0 of set 4 and Y way 1, then the X hit names way 1
      rows[6]  = '{1'b1, 20'h11114, 1'b0, 20'h00000, 20'h4b4b1, 4'b0011, 20'h0, 4'h0, 4'd1};
      rows[7]  = '{1'b1, 20'h22224, 1'b0, 20'h00000, 20'h78781, 4'b0011, 20'h0, 4'h0, 4'd1};
      rows[8]  = '{1'b1, 20'h11114, 1'b0, 20'h00000, 20'h4b4b1, 4'b0011, 20'h0, 4'h0, 4'd0};
      // Z evicts Y, X is kept, Y walks again
      rows[9]  = '{1'b1, 20'h33334, 1'b0, 20'h00000, 20'h69691, 4'b0011, 20'h0, 4'h0, 4'd1};
      rows[10] = '{1'b1, 20'h11114, 1'b0, 20'h00000, 20'h4b4b1, 4'b0011, 20'h0, 4'h0, 4'd0};
      rows[11] = '{1'b1, 20'h22224, 1'b0, 20'h00000, 20'h78781, 4'b0011, 20'h0, 4'h0, 4'd1};
      rows[12] = '{1'b1, 20'h22224, 1'b0, 20'h00000, 20'h78781, 4'b0011, 20'h0, 4'h0, 4'd0};
      // B alone
      rows[13] = '{1'b0, 20'h00000, 1'b1, 20'h4c0d5, 20'h0, 4'h0, 20'h16570, 4'b1101, 4'd1};
   endtask

   // Drive one row, wait for acceptance, then for the result
   task automatic apply_row(input row_t r);
      int waited;
      req_a.re  = r.re_a;
      req_a.vpn = r.vpn_a;
      req_b.re  = r.re_b;
      req_b.vpn = r.vpn_b;
      waited    = 0;
      // Ready high here means acceptance on the next rising edge
      while (!ready && waited < timeout_cycles) begin
         @(negedge clk);
         waited++;
      end
      if (!ready) begin
         $display("Request was never accepted, ready stayed low for %0d cycles", waited);
         timed_out = 1'b1;
      end else begin
         walks_before = walk_count;
         @(negedge clk);
         cycles = 1;
         while (!ready && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
         end
         if (!ready) begin
            $display("No result after %0d cycles, ready stayed low", cycles);
            timed_out = 1'b1;
         end
      end
   endtask

   task automatic check_row(input int idx, input row_t r);
      int delta;
      delta = walk_count - walks_before;
      if (r.re_a) begin
         assert (rsp_a.ppn == r.ppn_a) else begin
            $display("** Error: rsp_a.ppn = 0x%h, expected 0x%h (row %0d)",
                     rsp_a.ppn, r.ppn_a, idx);
            row_errors++;
         end
         assert (rsp_a.flags == r.flags_a) else begin
            $display("** Error: rsp_a.flags = 0x%h, expected 0x%h (row %0d)",
                     rsp_a.flags, r.flags_a, idx);
            row_errors++;
         end
      end
      if (r.re_b) begin
         assert (rsp_b.ppn == r.ppn_b) else begin
            $display("** Error: rsp_b.ppn = 0x%h, expected 0x%h (row %0d)",
                     rsp_b.ppn, r.ppn_b, idx);
            row_errors++;
         end
         assert (rsp_b.flags == r.flags_b) else begin
            $display("** Error: rsp_b.flags = 0x%h, expected 0x%h (row %0d)",
                     rsp_b.flags, r.flags_b, idx);
            row_errors++;
         end
      end
      assert (delta == int'(r.walks)) else begin
         $display("** Error: walk_count delta = 0x%h, expected 0x%h (row %0d)",
                  delta, r.walks, idx);
         row_errors++;
      end
      // Hits answer on the edge after acceptance
      if (r.walks == 4'd0) begin
         assert (cycles == 1) else begin
            $display("Hit on row %0d took %0d cycles instead of one", idx, cycles);
            row_errors++;
         end
      end
   endtask

   initial begin
      errors    = 0;
      timed_out = 1'b0;
      reset     = 1'b1;
      req_a     = '0;
      req_b     = '0;
      load_table();
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      for (int i = 0; i < row_count && !timed_out; i++) begin
         row_errors = 0;
         apply_row(rows[i]);
         if (timed_out) begin
            row_errors++;
            $display("row %0d: timed out", i);
         end else begin
            check_row(i, rows[i]);
            if (row_errors == 0) $display("row %0d: ok, %0d cycles", i, cycles);
            else $display("row %0d: %0d mismatches", i, row_errors);
         end
         errors += row_errors;
      end
      req_a.re = 1'b0;
      req_b.re = 1'b0;
      $display("rows %0d, errors %0d", row_count, errors);
      if (errors == 0 && !timed_out) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+hdl
hdl/dtlb_pkg.sv
hdl/dtlb_entry_ram.sv
hdl/dtlb_replace.sv
hdl/dtlb_ctrl.sv
hdl/dtlb_top.sv
tests/ptw_model.sv
tests/dtlb_tb.sv

// ==== Makefile ====
# Verilator simulation of the data TLB testbench

VERILATOR ?= verilator
TOP       ?= dtlb_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0

.PHONY: sim clean

# Build, run, and search the log for the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
